/* list.f */
mp5_pkg.sv
ingress_queue.sv
oldest_select.sv
egress_steer.sv
mp5_stage.sv
tb_mp5_stage.sv

/* tb_mp5_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mp5_stage
    import mp5_pkg::*;
;

    typedef enum {row_idle, row_push, row_insert, row_both} row_op_e;

    // one table row, applied for one cycle
    typedef struct {
        int          test;
        row_op_e     op;
        int          qid;
        logic [31:0] payload;
        logic [15:0] id;
        int          pipe;
        logic        phantom;
        int          ins_addr;  // -1 takes the reported phantom slot
        logic        hold;
    } row_t;

    // position of an accepted packet in its queue
    typedef struct {
        int q;
        int slot;
    } ent_t;

    logic                     clk;
    logic                     rst;
    pkt_t                     in_pkt;
    logic [QID_W-1:0]         in_qid;
    logic                     push;
    logic                     push_ready;
    logic                     insert;
    logic [ADDR_W-1:0]        insert_addr;
    logic                     hold;
    logic [NUM_PIPELINES-1:0] out_valid;
    pkt_t                     out_pkt [NUM_PIPELINES];
    logic                     phantom_valid;
    logic [15:0]              phantom_id;
    logic [ADDR_W-1:0]        phantom_addr;

    row_t  table_rows [$];
    bit    rows_ready;
    int    seed = 95;
    int    cur_test;
    int    test_err [0:5];
    int    n_checks;
    int    n_mismatch;
    int    tests_passed;
    int    tests_failed;

    // reference model
    ent_t                     order_q [$];
    pkt_t                     slot_mem [NUM_INPUTS][FIFO_DEPTH];
    int                       occ [NUM_INPUTS];
    int                       push_cnt [NUM_INPUTS];
    logic [NUM_PIPELINES-1:0] exp_valid;
    pkt_t                     exp_pkt;
    logic                     exp_ph_valid;
    logic [15:0]              exp_ph_id;
    logic [ADDR_W-1:0]        exp_ph_addr;
    logic [ADDR_W-1:0]        ph_slot;

    mp5_stage mp5_stage_i (
        .clk           (clk),
        .rst           (rst),
        .in_pkt        (in_pkt),
        .in_qid        (in_qid),
        .push          (push),
        .push_ready    (push_ready),
        .insert        (insert),
        .insert_addr   (insert_addr),
        .hold          (hold),
        .out_valid     (out_valid),
        .out_pkt       (out_pkt),
        .phantom_valid (phantom_valid),
        .phantom_id    (phantom_id),
        .phantom_addr  (phantom_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        n_checks++;
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
            n_mismatch++;
            test_err[cur_test]++;
        end
    endtask

    task automatic add_row(input int test, input row_op_e op, input int qid, input int pipe,
                           input logic [15:0] id, input logic phantom, input int ins_addr,
                           input logic hold_val);
        row_t r;
        r.test     = test;
        r.op       = op;
        r.qid      = qid;
        r.payload  = $random(seed);
        r.id       = id;
        r.pipe     = pipe;
        r.phantom  = phantom;
        r.ins_addr = ins_addr;
        r.hold     = hold_val;
        table_rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        pkt_t p;
        p.payload  = r.payload;
        p.id       = r.id;
        p.pipeline = PIPE_W'(r.pipe);
        p.phantom  = r.phantom;
        in_pkt      <= p;
        in_qid      <= QID_W'(r.qid);
        push        <= (r.op == row_push) || (r.op == row_both);
        insert      <= (r.op == row_insert) || (r.op == row_both);
        insert_addr <= (r.ins_addr < 0) ? ph_slot : ADDR_W'(r.ins_addr);
        hold        <= r.hold;
    endtask

    task automatic report_test(input int t);
        string title;
        case (t)
            1: title = "reset state";
            2: title = "global order and steering";
            3: title = "back-pressure";
            4: title = "phantom report";
            default: title = "insert";
        endcase
        if (test_err[t] == 0) begin
            $display("test %0d %s: PASS", t, title);
            tests_passed++;
        end else begin
            $display("test %0d %s: FAIL with %0d mismatches", t, title, test_err[t]);
            tests_failed++;
        end
    endtask

    task automatic build_table();
        // 1: idle with every queue addressed once
        for (int i = 0; i < NUM_INPUTS; i++) begin
            add_row(1, row_idle, i, 0, 16'h0, 1'b0, 0, 1'b0);
        end
        // 2: spread over all queues, hold pulsed in the second half
        for (int i = 0; i < 12; i++) begin
            add_row(2, row_push, i % NUM_INPUTS, 3 - (i % 4), 16'h0200 + i, 1'b0, 0, 1'b0);
        end
        for (int i = 12; i < 20; i++) begin
            add_row(2, row_push, (i * 3) % NUM_INPUTS, i % 4, 16'h0200 + i, 1'b0, 0,
                    (i % 3) == 0);
        end
        for (int i = 0; i < 8; i++) begin
            add_row(2, row_idle, 0, 0, 16'h0, 1'b0, 0, 1'b0);
        end
        // 3: fill queue 2, the last push is refused
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            add_row(3, row_push, 2, i % 4, 16'h0300 + i, 1'b0, 0, 1'b1);
        end
        add_row(3, row_idle, 1, 0, 16'h0, 1'b0, 0, 1'b1);
        add_row(3, row_idle, 0, 0, 16'h0, 1'b0, 0, 1'b1);
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            add_row(3, row_idle, 0, 0, 16'h0, 1'b0, 0, 1'b0);
        end
        // 4: phantoms after a few packets, the second one on a wrapped tail
        for (int i = 0; i < 3; i++) begin
            add_row(4, row_push, 1, i, 16'h0400 + i, 1'b0, 0, 1'b0);
        end
        add_row(4, row_push, 1, 3, 16'h0410, 1'b1, 0, 1'b0);
        add_row(4, row_push, 2, 1, 16'h0411, 1'b1, 0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            add_row(4, row_idle, 0, 0, 16'h0, 1'b0, 0, 1'b0);
        end
        // 5: overwrite the phantom while stalled, then a push that carries an insert
        add_row(5, row_push, 0, 0, 16'h0500, 1'b0, 0, 1'b1);
        add_row(5, row_push, 3, 1, 16'h0501, 1'b1, 0, 1'b1);
        add_row(5, row_push, 0, 2, 16'h0502, 1'b0, 0, 1'b1);
        add_row(5, row_idle, 3, 0, 16'h0, 1'b0, 0, 1'b1);
        add_row(5, row_insert, 3, 3, 16'h0510, 1'b0, -1, 1'b1);
        add_row(5, row_both, 3, 0, 16'h0520, 1'b0, -1, 1'b1);
        for (int i = 0; i < 8; i++) begin
            add_row(5, row_idle, 0, 0, 16'h0, 1'b0, 0, 1'b0);
        end
    endtask

    // state after the last edge, inputs for the next one
    always @(negedge clk) begin
        ent_t              ent;
        int                slot;
        logic              ready_exp;
        if (!rst) begin
            check("out_valid", out_valid, exp_valid);
            for (int p = 0; p < NUM_PIPELINES; p++) begin
                if (exp_valid[p]) begin
                    check($sformatf("out_pkt[%0d]", p), out_pkt[p], exp_pkt);
                end
            end
            check("phantom_valid", phantom_valid, exp_ph_valid);
            if (exp_ph_valid) begin
                check("phantom_id", phantom_id, exp_ph_id);
                check("phantom_addr", phantom_addr, exp_ph_addr);
            end
            if (phantom_valid) begin
                ph_slot = phantom_addr;
            end

            ready_exp = occ[in_qid] < FIFO_DEPTH;
            check("push_ready", push_ready, ready_exp);
            exp_valid    = '0;
            exp_ph_valid = 1'b0;

            // one pop per cycle, oldest accepted packet first
            if (!hold && order_q.size() > 0) begin
                ent = order_q.pop_front();
                exp_pkt = slot_mem[ent.q][ent.slot];
                exp_valid[exp_pkt.pipeline] = 1'b1;
                occ[ent.q]--;
            end

            if (push && ready_exp) begin
                slot = push_cnt[in_qid] % FIFO_DEPTH;
                slot_mem[in_qid][slot] = in_pkt;
                ent.q    = in_qid;
                ent.slot = slot;
                order_q.push_back(ent);
                occ[in_qid]++;
                push_cnt[in_qid]++;
                if (in_pkt.phantom) begin
                    exp_ph_valid = 1'b1;
                    exp_ph_id    = in_pkt.id;
                    exp_ph_addr  = ADDR_W'(slot);
                end
            end else if (!push && insert) begin
                slot_mem[in_qid][insert_addr] = in_pkt;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (rows_ready);
        limit = table_rows.size() + 4 * FIFO_DEPTH * NUM_INPUTS + 20;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        in_pkt       = '0;
        in_qid       = '0;
        push         = 1'b0;
        insert       = 1'b0;
        insert_addr  = '0;
        hold         = 1'b0;
        exp_valid    = '0;
        exp_pkt      = '0;
        exp_ph_valid = 1'b0;
        exp_ph_id    = '0;
        exp_ph_addr  = '0;
        ph_slot      = '0;
        cur_test     = 0;

        build_table();
        rows_ready = 1'b1;

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        foreach (table_rows[i]) begin
            @(posedge clk);
            if (table_rows[i].test != cur_test && cur_test != 0) begin
                report_test(cur_test);
            end
            cur_test = table_rows[i].test;
            apply_row(table_rows[i]);
        end

        @(posedge clk);
        push   <= 1'b0;
        insert <= 1'b0;
        hold   <= 1'b0;
        repeat (2) @(negedge clk);
        report_test(cur_test);

        $display("tests passed %0d, tests failed %0d, checks %0d, mismatches %0d",
                 tests_passed, tests_failed, n_checks, n_mismatch);
        if (tests_failed == 0 && n_mismatch == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mp5_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mp5_stage
    import mp5_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,

    // ingress
    input  wire pkt_t                in_pkt,
    input  wire [QID_W-1:0]          in_qid,
    input  wire                      push,
    output logic                     push_ready,
    input  wire                      insert,
    input  wire [ADDR_W-1:0]         insert_addr,

    // downstream stall
    input  wire                      hold,

    // egress
    output logic [NUM_PIPELINES-1:0] out_valid,
    output pkt_t                     out_pkt [NUM_PIPELINES],

    // where the last phantom landed
    output logic                     phantom_valid,
    output logic [15:0]              phantom_id,
    output logic [ADDR_W-1:0]        phantom_addr
);

    ts_t                 cur_time;
    wr_op_e              q_op      [NUM_INPUTS];
    pkt_t                head_pkt  [NUM_INPUTS];
    ts_t                 head_ts   [NUM_INPUTS];
    logic [ADDR_W-1:0]   tail_addr [NUM_INPUTS];
    logic [NUM_INPUTS-1:0] q_empty;
    logic [NUM_INPUTS-1:0] q_full;
    logic [NUM_INPUTS-1:0] q_pop;
    logic                pop_valid;
    logic [QID_W-1:0]    pop_qid;
    logic                push_acc;

    // free-running timestamp
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_time <= '0;
        end else begin
            cur_time <= cur_time + 1'b1;
        end
    end

    assign push_ready = !q_full[in_qid];
    assign push_acc   = push && push_ready;

    // push wins over insert, even a refused one
    always_comb begin
        for (int i = 0; i < NUM_INPUTS; i++) begin
            q_op[i] = op_none;
            if (in_qid == QID_W'(i)) begin
                if (push_acc) begin
                    q_op[i] = op_push;
                end else if (!push && insert) begin
                    q_op[i] = op_insert;
                end
            end
        end
    end

    for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_queue
        ingress_queue ingress_queue_i (
            .clk         (clk),
            .rst         (rst),
            .op          (q_op[i]),
            .wr_pkt      (in_pkt),
            .wr_ts       (cur_time),
            .insert_addr (insert_addr),
            .pop         (q_pop[i]),
            .head_pkt    (head_pkt[i]),
            .head_ts     (head_ts[i]),
            .tail_addr   (tail_addr[i]),
            .empty       (q_empty[i]),
            .full        (q_full[i])
        );

        // full queue without a pop stays closed next cycle
        full_blocks_push: assert property (
            @(posedge clk) disable iff (rst)
            (q_full[i] && !q_pop[i]) |=> !(push_ready && (in_qid == QID_W'(i)))
        ) else $error("push_ready high for a full queue");
    end

    oldest_select oldest_select_i (
        .head_ts   (head_ts),
        .empty     (q_empty),
        .pop_valid (pop_valid),
        .pop_qid   (pop_qid)
    );

    egress_steer egress_steer_i (
        .clk       (clk),
        .rst       (rst),
        .hold      (hold),
        .pop_valid (pop_valid),
        .pop_qid   (pop_qid),
        .head_pkt  (head_pkt),
        .pop       (q_pop),
        .out_valid (out_valid),
        .out_pkt   (out_pkt)
    );

    // phantom report
    always_ff @(posedge clk) begin
        if (rst) begin
            phantom_valid <= 1'b0;
        end else begin
            phantom_valid <= push_acc && in_pkt.phantom;
        end
    end

    always_ff @(posedge clk) begin
        if (push_acc && in_pkt.phantom) begin
            phantom_id   <= in_pkt.id;
            phantom_addr <= tail_addr[in_qid];
        end
    end

endmodule

`default_nettype wire

/* egress_steer.sv */
`timescale 1ns/100ps
`default_nettype none

module egress_steer
    import mp5_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      hold,

    // decision from the selector
    input  wire                      pop_valid,
    input  wire [QID_W-1:0]          pop_qid,
    input  wire pkt_t                head_pkt [NUM_INPUTS],

    // back to the queues
    output logic [NUM_INPUTS-1:0]    pop,

    // egress ports
    output logic [NUM_PIPELINES-1:0] out_valid,
    output pkt_t                     out_pkt [NUM_PIPELINES]
);

    logic pop_go;
    pkt_t sel_pkt;

    // downstream stalls the whole stage
    assign pop_go  = pop_valid && !hold;
    assign sel_pkt = head_pkt[pop_qid];

    always_comb begin
        pop          = '0;
        pop[pop_qid] = pop_go;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= '0;
        end else begin
            out_valid <= '0;
            if (pop_go) begin
                out_valid[sel_pkt.pipeline] <= 1'b1;
            end
        end
    end

    // packet goes to the port named by its pipeline field
    always_ff @(posedge clk) begin
        if (pop_go) begin
            out_pkt[sel_pkt.pipeline] <= sel_pkt;
        end
    end

    one_egress_per_cycle: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(out_valid)
    ) else $error("more than one egress port valid");

endmodule

`default_nettype wire

/* oldest_select.sv */
`timescale 1ns/100ps
`default_nettype none

module oldest_select
    import mp5_pkg::*;
(
    input  wire ts_t             head_ts [NUM_INPUTS],
    input  wire [NUM_INPUTS-1:0] empty,
    output logic                 pop_valid,
    output logic [QID_W-1:0]     pop_qid
);

    localparam int NODES = 2 * NUM_INPUTS - 1;

    // heap layout, node k has children 2k+1 and 2k+2
    // leaves sit at NUM_INPUTS-1 upward, left child always holds the lower queues
    wire ts_t             node_ts  [NODES];
    wire                  node_vld [NODES];
    wire [QID_W-1:0]      node_qid [NODES];

    for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_leaf
        assign node_ts[NUM_INPUTS-1+i]  = head_ts[i];
        assign node_vld[NUM_INPUTS-1+i] = !empty[i];
        assign node_qid[NUM_INPUTS-1+i] = QID_W'(i);
    end

    for (genvar k = 0; k < NUM_INPUTS - 1; k++) begin : g_node
        wire take_left;

        // empty side loses, equal times go left
        assign take_left = node_vld[2*k+1] &&
                           (!node_vld[2*k+2] || (node_ts[2*k+1] <= node_ts[2*k+2]));

        assign node_ts[k]  = take_left ? node_ts[2*k+1]  : node_ts[2*k+2];
        assign node_qid[k] = take_left ? node_qid[2*k+1] : node_qid[2*k+2];
        assign node_vld[k] = node_vld[2*k+1] || node_vld[2*k+2];
    end

    // root carries the winner
    assign pop_valid = node_vld[0];
    assign pop_qid   = node_qid[0];

endmodule

`default_nettype wire

/* ingress_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module ingress_queue
    import mp5_pkg::*;
(
    input  wire               clk,
    input  wire               rst,

    // write side
    input  wire wr_op_e       op,
    input  wire pkt_t         wr_pkt,
    input  wire ts_t          wr_ts,
    input  wire [ADDR_W-1:0]  insert_addr,

    // read side
    input  wire               pop,
    output pkt_t              head_pkt,
    output ts_t               head_ts,

    // status
    output logic [ADDR_W-1:0] tail_addr,
    output logic              empty,
    output logic              full
);

    pkt_t pkt_mem [FIFO_DEPTH];
    ts_t  ts_mem  [FIFO_DEPTH];

    // one extra bit tells full from empty
    logic [ADDR_W:0]   head_ptr;
    logic [ADDR_W:0]   tail_ptr;
    logic [ADDR_W-1:0] head_addr;
    logic              do_push;
    logic              do_pop;

    assign head_addr = head_ptr[ADDR_W-1:0];
    assign tail_addr = tail_ptr[ADDR_W-1:0];

    assign empty = (head_ptr == tail_ptr);
    assign full  = (head_ptr[ADDR_W] != tail_ptr[ADDR_W]) && (head_addr == tail_addr);

    assign do_push = (op == op_push) && !full;
    assign do_pop  = pop && !empty;

    // head is read straight from the array
    assign head_pkt = pkt_mem[head_addr];
    assign head_ts  = ts_mem[head_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (do_push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (do_pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (op)
            op_push: begin
                if (!full) begin
                    pkt_mem[tail_addr] <= wr_pkt;
                    ts_mem[tail_addr]  <= wr_ts;
                end
            end
            op_insert: begin
                // slot keeps its original arrival time
                pkt_mem[insert_addr] <= wr_pkt;
            end
            default: begin
            end
        endcase
    end

    // the top only pushes when the queue reported room
    push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        (op == op_push) |-> !full
    ) else $error("push to a full queue");

    // the selector never picks an empty queue
    pop_when_empty: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> !empty
    ) else $error("pop from an empty queue");

endmodule

`default_nettype wire

/* mp5_pkg.sv */
`default_nettype none

package mp5_pkg;

    // stage geometry
    localparam int NUM_INPUTS    = 4;
    localparam int NUM_PIPELINES = 4;
    localparam int FIFO_DEPTH    = 8;

    // derived widths
    localparam int QID_W  = $clog2(NUM_INPUTS);
    localparam int PIPE_W = $clog2(NUM_PIPELINES);
    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    // wrap of the cycle counter is not handled
    localparam int TS_W      = 32;
    localparam int PAYLOAD_W = 32;

    // arrival time of a packet in a queue
    typedef logic [TS_W-1:0] ts_t;

    // packet as it moves through the stage
    typedef struct packed {
        logic [PAYLOAD_W-1:0] payload;
        // phantom header part
        logic [15:0]          id;
        logic [PIPE_W-1:0]    pipeline;
        logic                 phantom;
    } pkt_t;

    // write command seen by one queue
    typedef enum logic [1:0] {
        op_none   = 2'd0,
        op_push   = 2'd1,
        op_insert = 2'd2
    } wr_op_e;

endpackage

`default_nettype wire
